//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timing
TOP       := copper_tb
FILELIST  := src.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- copper.sv
// Copper top level, wiring of PC unit, sequencer and executor
// Program memory is external with one cycle of read latency
// XR writes have no back-pressure and always complete at once
`timescale 1ns/100ps
`include "copper_defines.svh"

module copper (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          vblank_i,
    input  logic                          reg_wr_i,
    input  logic [`COPPER_REG_NUM_W-1:0]  reg_num_i,
    input  logic [`COPPER_WORD_W-1:0]     reg_data_i,
    input  logic [`COPPER_POS_W-1:0]      h_count_i,
    input  logic [`COPPER_POS_W-1:0]      v_count_i,
    input  logic [`COPPER_WORD_W-1:0]     coppermem_rd_data_i,
    output logic                          coppermem_rd_en_o,
    output logic [`COPPER_PC_W-1:0]       coppermem_rd_addr_o,
    output logic                          xr_wr_en_o,
    output logic [`COPPER_WORD_W-1:0]     xr_wr_addr_o,
    output logic [`COPPER_WORD_W-1:0]     xr_wr_data_o
);

    logic                    enable;
    logic                    latch_hi;
    logic                    latch_lo;
    logic                    pc_inc;
    logic                    pc_skip;
    logic                    pc_jump;
    logic                    move;
    logic                    pos_reached;
    logic [`COPPER_PC_W-1:0] jump_target;
    copper_isa_pkg::opcode_t opcode;

    // Read enable doubles as the fetch indication for the PC
    copper_pc_unit pc_unit_i (
        .clk                 (clk),
        .reset_i             (reset_i),
        .vblank_i            (vblank_i),
        .reg_wr_i            (reg_wr_i),
        .reg_num_i           (reg_num_i),
        .reg_data_i          (reg_data_i),
        .fetch_i             (coppermem_rd_en_o),
        .pc_inc_i            (pc_inc),
        .pc_skip_i           (pc_skip),
        .pc_jump_i           (pc_jump),
        .jump_target_i       (jump_target),
        .enable_o            (enable),
        .coppermem_rd_addr_o (coppermem_rd_addr_o)
    );

    copper_sequencer sequencer_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .vblank_i          (vblank_i),
        .enable_i          (enable),
        .opcode_i          (opcode),
        .pos_reached_i     (pos_reached),
        .coppermem_rd_en_o (coppermem_rd_en_o),
        .latch_hi_o        (latch_hi),
        .latch_lo_o        (latch_lo),
        .pc_inc_o          (pc_inc),
        .pc_skip_o         (pc_skip),
        .pc_jump_o         (pc_jump),
        .move_o            (move)
    );

    copper_executor executor_i (
        .clk                 (clk),
        .reset_i             (reset_i),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .latch_hi_i          (latch_hi),
        .latch_lo_i          (latch_lo),
        .move_i              (move),
        .h_count_i           (h_count_i),
        .v_count_i           (v_count_i),
        .opcode_o            (opcode),
        .pos_reached_o       (pos_reached),
        .jump_target_o       (jump_target),
        .xr_wr_en_o          (xr_wr_en_o),
        .xr_wr_addr_o        (xr_wr_addr_o),
        .xr_wr_data_o        (xr_wr_data_o)
    );

endmodule

//--- copper_bus_pkg.sv
// XR bus constants the copper needs, not the full XR map
// Region bases must be aligned to the address width of their MOVE variant
`include "copper_defines.svh"

package copper_bus_pkg;

    // Control register: [15] enable, [10:0] initial PC
    localparam logic [`COPPER_REG_NUM_W-1:0] XR_COPP_CTRL = 4'h1;

    // Tile memory, 4K words
    localparam logic [`COPPER_WORD_W-1:0] XR_TILE_MEM = 16'h4000;

    // Colour memory, 256 entries
    localparam logic [`COPPER_WORD_W-1:0] XR_COLOR_MEM = 16'h8000;

    // Copper program memory, 2K words
    localparam logic [`COPPER_WORD_W-1:0] XR_COPPER_MEM = 16'hC000;

endpackage

//--- copper_defines.svh
// Widths and field sizes shared by the copper RTL and its testbench
// Instructions are two 16-bit words with the high word at the lower address
`ifndef COPPER_DEFINES_SVH
`define COPPER_DEFINES_SVH

// Bus and memory word
`define COPPER_WORD_W       16
// Full instruction, two words
`define COPPER_INSN_W       32
`define COPPER_OP_W         4

// Copper memory is 2K words
`define COPPER_PC_W         11
`define COPPER_POS_W        11
`define COPPER_REG_NUM_W    4
`define COPPER_STATE_W      3

// Enable bit of the control register, init PC sits in the low bits
`define COPPER_CTRL_EN_BIT  15

// Address field of the move view
`define COPPER_MOVE_ADDR_W  12
// Usable address bits per MOVE target
`define COPPER_MOVER_AW     8
`define COPPER_MOVEF_AW     12
`define COPPER_MOVEP_AW     8
`define COPPER_MOVEC_AW     11

`endif

//--- copper_executor.sv
// Instruction register, beam compare and XR write formation
// Compares are >= on each axis, so a position counts as reached once passed
// XR address and data are only meaningful while xr_wr_en_o is high
`timescale 1ns/100ps
`include "copper_defines.svh"

module copper_executor (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [`COPPER_WORD_W-1:0]   coppermem_rd_data_i,
    input  logic                        latch_hi_i,
    input  logic                        latch_lo_i,
    input  logic                        move_i,
    input  logic [`COPPER_POS_W-1:0]    h_count_i,
    input  logic [`COPPER_POS_W-1:0]    v_count_i,
    output copper_isa_pkg::opcode_t     opcode_o,
    output logic                        pos_reached_o,
    output logic [`COPPER_PC_W-1:0]     jump_target_o,
    output logic                        xr_wr_en_o,
    output logic [`COPPER_WORD_W-1:0]   xr_wr_addr_o,
    output logic [`COPPER_WORD_W-1:0]   xr_wr_data_o
);

    copper_isa_pkg::insn_t     insn;
    logic                      x_ok;
    logic                      y_ok;
    logic                      both_ignored;
    logic                      is_wait;
    logic [`COPPER_WORD_W-1:0] move_addr;

    // Keep the base above aw bits, take the field below
    function automatic logic [`COPPER_WORD_W-1:0] region_addr(
        input logic [`COPPER_WORD_W-1:0]     base,
        input logic [`COPPER_MOVE_ADDR_W-1:0] field,
        input int unsigned                   aw
    );
        logic [`COPPER_WORD_W-1:0] mask;
        mask = (`COPPER_WORD_W'(1) << aw) - `COPPER_WORD_W'(1);
        return (base & ~mask) | (`COPPER_WORD_W'(field) & mask);
    endfunction

    // High word first, then the low word one cycle later
    always_ff @(posedge clk) begin
        if (latch_hi_i) begin
            insn[`COPPER_INSN_W-1:`COPPER_WORD_W] <= coppermem_rd_data_i;
        end
        if (latch_lo_i) begin
            insn[`COPPER_WORD_W-1:0] <= coppermem_rd_data_i;
        end
    end

    assign opcode_o      = insn.mv.opcode;
    // JMP target is carried in the y field position
    assign jump_target_o = insn.mv.addr[`COPPER_PC_W-1:0];

    // Per-axis beam condition
    assign x_ok = insn.pos.ignore_x || (h_count_i >= insn.pos.x);
    assign y_ok = insn.pos.ignore_y || (v_count_i >= insn.pos.y);

    // Both axes ignored: SKIP always skips, WAIT parks until vblank
    assign both_ignored  = insn.pos.ignore_x && insn.pos.ignore_y;
    assign is_wait       = (insn.pos.opcode == copper_isa_pkg::OP_WAIT);
    assign pos_reached_o = x_ok && y_ok && !(is_wait && both_ignored);

    // Target region per MOVE variant
    always_comb begin
        case (insn.mv.opcode)
            copper_isa_pkg::OP_MOVEF: begin
                move_addr = region_addr(copper_bus_pkg::XR_TILE_MEM, insn.mv.addr,
                                        `COPPER_MOVEF_AW);
            end
            copper_isa_pkg::OP_MOVEP: begin
                move_addr = region_addr(copper_bus_pkg::XR_COLOR_MEM, insn.mv.addr,
                                        `COPPER_MOVEP_AW);
            end
            copper_isa_pkg::OP_MOVEC: begin
                move_addr = region_addr(copper_bus_pkg::XR_COPPER_MEM, insn.mv.addr,
                                        `COPPER_MOVEC_AW);
            end
            default: begin
                // MOVER, XR registers sit at the bottom of the map
                move_addr = region_addr('0, insn.mv.addr, `COPPER_MOVER_AW);
            end
        endcase
    end

    // One-cycle strobe after EXEC
    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_wr_en_o <= 1'b0;
        end else begin
            xr_wr_en_o <= move_i;
        end
    end

    always_ff @(posedge clk) begin
        if (move_i) begin
            xr_wr_addr_o <= move_addr;
            xr_wr_data_o <= insn.mv.data;
        end
    end

endmodule

//--- copper_isa_pkg.sv
// Copper instruction set: opcodes, FSM states and the instruction word layout
// Any opcode outside opcode_t is illegal and skipped by the copper
`include "copper_defines.svh"

package copper_isa_pkg;

    // Opcode lives in the top nibble of the first word
    typedef enum logic [`COPPER_OP_W-1:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEF = 4'b1010,
        OP_MOVEP = 4'b1011,
        OP_MOVEC = 4'b1100
    } opcode_t;

    typedef enum logic [`COPPER_STATE_W-1:0] {
        ST_INIT     = 3'd0,
        ST_FETCH    = 3'd1,
        ST_LATCH_HI = 3'd2,
        ST_LATCH_LO = 3'd3,
        ST_EXEC     = 3'd4
    } ex_state_t;

    // One 32-bit instruction, decoded either as a beam position or a move
    typedef union packed {
        // WAIT, SKIP and JMP (JMP target shares the y field)
        struct packed {
            opcode_t                  opcode;
            logic                     rsv_y;
            logic [`COPPER_POS_W-1:0] y;
            logic                     rsv_x;
            logic [`COPPER_POS_W-1:0] x;
            logic [1:0]               rsv_f;
            logic                     ignore_x;
            logic                     ignore_y;
        } pos;
        // MOVER, MOVEF, MOVEP, MOVEC
        struct packed {
            opcode_t                        opcode;
            logic [`COPPER_MOVE_ADDR_W-1:0] addr;
            logic [`COPPER_WORD_W-1:0]      data;
        } mv;
    } insn_t;

endpackage

//--- copper_pc_unit.sv
// Control register and program counter
// While disabled or in vblank the PC tracks the initial PC, so a new
// control write takes effect on the first enabled cycle
`timescale 1ns/100ps
`include "copper_defines.svh"

module copper_pc_unit (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          vblank_i,
    input  logic                          reg_wr_i,
    input  logic [`COPPER_REG_NUM_W-1:0]  reg_num_i,
    input  logic [`COPPER_WORD_W-1:0]     reg_data_i,
    input  logic                          fetch_i,
    input  logic                          pc_inc_i,
    input  logic                          pc_skip_i,
    input  logic                          pc_jump_i,
    input  logic [`COPPER_PC_W-1:0]       jump_target_i,
    output logic                          enable_o,
    output logic [`COPPER_PC_W-1:0]       coppermem_rd_addr_o
);

    logic                    ctrl_wr;
    logic [`COPPER_PC_W-1:0] init_pc;
    logic [`COPPER_PC_W-1:0] init_pc_next;
    logic [`COPPER_PC_W-1:0] pc;
    logic                    fetch_q;
    logic                    first_fetch;

    // Only the control register is decoded here
    assign ctrl_wr = reg_wr_i && (reg_num_i == copper_bus_pkg::XR_COPP_CTRL);

    // Reload value sees a control write in the same cycle
    assign init_pc_next = ctrl_wr ? reg_data_i[`COPPER_PC_W-1:0] : init_pc;

    // Reads come in pairs, the first one steps to the second word
    assign first_fetch = fetch_i && !fetch_q;

    assign coppermem_rd_addr_o = pc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_o <= 1'b0;
            init_pc  <= '0;
            pc       <= '0;
            fetch_q  <= 1'b0;
        end else begin
            fetch_q <= fetch_i;

            if (ctrl_wr) begin
                enable_o <= reg_data_i[`COPPER_CTRL_EN_BIT];
                init_pc  <= reg_data_i[`COPPER_PC_W-1:0];
            end

            // Restart point for every frame
            if (vblank_i || !enable_o) begin
                pc <= init_pc_next;
            end else if (pc_jump_i) begin
                pc <= jump_target_i;
            end else if (pc_skip_i) begin
                // From the second word, 3 lands past the next instruction
                pc <= pc + `COPPER_PC_W'(3);
            end else if (pc_inc_i || first_fetch) begin
                pc <= pc + `COPPER_PC_W'(1);
            end
        end
    end

endmodule

//--- copper_sequencer.sv
// Execution FSM of the copper, all outputs decoded from the current state
// Four cycles per instruction, five after INIT; a WAIT holds EXEC
// Outputs are quiet while disabled or in vblank
`timescale 1ns/100ps

module copper_sequencer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    vblank_i,
    input  logic                    enable_i,
    input  copper_isa_pkg::opcode_t opcode_i,
    input  logic                    pos_reached_i,
    output logic                    coppermem_rd_en_o,
    output logic                    latch_hi_o,
    output logic                    latch_lo_o,
    output logic                    pc_inc_o,
    output logic                    pc_skip_o,
    output logic                    pc_jump_o,
    output logic                    move_o
);

    copper_isa_pkg::ex_state_t state;
    copper_isa_pkg::ex_state_t state_next;
    logic                      run;
    logic                      exec;
    logic                      is_move;
    logic                      is_legal;
    logic                      advance;

    assign run  = enable_i && !vblank_i;
    assign exec = run && (state == copper_isa_pkg::ST_EXEC);

    // Opcode classes
    always_comb begin
        is_move  = 1'b0;
        is_legal = 1'b1;
        case (opcode_i)
            copper_isa_pkg::OP_WAIT,
            copper_isa_pkg::OP_SKIP,
            copper_isa_pkg::OP_JMP: begin
                is_move = 1'b0;
            end
            copper_isa_pkg::OP_MOVER,
            copper_isa_pkg::OP_MOVEF,
            copper_isa_pkg::OP_MOVEP,
            copper_isa_pkg::OP_MOVEC: begin
                is_move = 1'b1;
            end
            default: begin
                is_legal = 1'b0;
            end
        endcase
    end

    // A WAIT only leaves EXEC once the beam is there
    assign advance = (opcode_i != copper_isa_pkg::OP_WAIT) || pos_reached_i;

    always_comb begin
        state_next = state;
        case (state)
            copper_isa_pkg::ST_INIT:     state_next = copper_isa_pkg::ST_FETCH;
            copper_isa_pkg::ST_FETCH:    state_next = copper_isa_pkg::ST_LATCH_HI;
            copper_isa_pkg::ST_LATCH_HI: state_next = copper_isa_pkg::ST_LATCH_LO;
            copper_isa_pkg::ST_LATCH_LO: state_next = copper_isa_pkg::ST_EXEC;
            copper_isa_pkg::ST_EXEC: begin
                // Illegal opcode costs the extra INIT cycle
                if (!is_legal) begin
                    state_next = copper_isa_pkg::ST_INIT;
                end else if (advance) begin
                    state_next = copper_isa_pkg::ST_FETCH;
                end
            end
            default: state_next = copper_isa_pkg::ST_INIT;
        endcase
        // Vblank or disable parks the FSM
        if (!run) begin
            state_next = copper_isa_pkg::ST_INIT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= copper_isa_pkg::ST_INIT;
        end else begin
            state <= state_next;
        end
    end

    // Word 0 is read in FETCH, word 1 in LATCH_HI
    assign coppermem_rd_en_o = run && ((state == copper_isa_pkg::ST_FETCH) ||
                                       (state == copper_isa_pkg::ST_LATCH_HI));
    assign latch_hi_o = run && (state == copper_isa_pkg::ST_LATCH_HI);
    assign latch_lo_o = run && (state == copper_isa_pkg::ST_LATCH_LO);

    // PC actions in EXEC, at most one at a time
    assign pc_jump_o = exec && (opcode_i == copper_isa_pkg::OP_JMP);
    assign pc_skip_o = exec && (opcode_i == copper_isa_pkg::OP_SKIP) && pos_reached_i;
    assign pc_inc_o  = exec && advance && !pc_jump_o && !pc_skip_o;

    assign move_o = exec && is_move;

endmodule

//--- copper_tb.sv
// Copper testbench on a 32 x 12 raster with lines 10 and 11 in vblank
// Programs are loaded and the control register written while in vblank
// Write timing is given as the beam position at which the strobe is sampled
`timescale 1ns/100ps
`include "copper_defines.svh"

module copper_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int H_TOTAL      = 32;
    localparam int V_TOTAL      = 12;
    localparam int V_VISIBLE    = 10;
    localparam int NUM_FRAMES   = 6;
    // Program load plus control write between frames
    localparam int LOAD_CYCLES  = 40;
    localparam int WATCHDOG_NS  = 2 * CLK_PERIOD *
        (RESET_CYCLES + NUM_FRAMES * (H_TOTAL * V_TOTAL + LOAD_CYCLES));

    logic                         clk;
    logic                         reset_i;
    logic                         vblank_i;
    logic                         reg_wr_i;
    logic [`COPPER_REG_NUM_W-1:0] reg_num_i;
    logic [`COPPER_WORD_W-1:0]    reg_data_i;
    logic [`COPPER_POS_W-1:0]     h_count_i;
    logic [`COPPER_POS_W-1:0]     v_count_i;
    logic [`COPPER_WORD_W-1:0]    coppermem_rd_data_i;
    logic                         coppermem_rd_en_o;
    logic [`COPPER_PC_W-1:0]      coppermem_rd_addr_o;
    logic                         xr_wr_en_o;
    logic [`COPPER_WORD_W-1:0]    xr_wr_addr_o;
    logic [`COPPER_WORD_W-1:0]    xr_wr_data_o;
    logic                         load_en;
    logic [`COPPER_PC_W-1:0]      load_addr;
    logic [`COPPER_WORD_W-1:0]    load_data;

    // Program under construction and the expected XR writes, in order
    logic [31:0]               prog[$];
    logic [`COPPER_WORD_W-1:0] exp_addr[$];
    logic [`COPPER_WORD_W-1:0] exp_data[$];
    int                        exp_at[$];
    int                        writes_seen;
    // Last frame in which each program word was fetched
    int                        fetch_frame [0:(1 << `COPPER_PC_W)-1];
    int                        first_fetch_frame;
    int                        frame_no;
    bit                        copper_on;
    logic [`COPPER_PC_W-1:0]   exp_init_pc;

    copper dut_i (
        .clk                 (clk),
        .reset_i             (reset_i),
        .vblank_i            (vblank_i),
        .reg_wr_i            (reg_wr_i),
        .reg_num_i           (reg_num_i),
        .reg_data_i          (reg_data_i),
        .h_count_i           (h_count_i),
        .v_count_i           (v_count_i),
        .coppermem_rd_data_i (coppermem_rd_data_i),
        .coppermem_rd_en_o   (coppermem_rd_en_o),
        .coppermem_rd_addr_o (coppermem_rd_addr_o),
        .xr_wr_en_o          (xr_wr_en_o),
        .xr_wr_addr_o        (xr_wr_addr_o),
        .xr_wr_data_o        (xr_wr_data_o)
    );

    copper_tb_mem mem_i (
        .clk         (clk),
        .rd_en_i     (coppermem_rd_en_o),
        .rd_addr_i   (coppermem_rd_addr_o),
        .rd_data_o   (coppermem_rd_data_i),
        .load_en_i   (load_en),
        .load_addr_i (load_addr),
        .load_data_i (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Each MOVE variant ORs its usable field bits into the region base
    function automatic logic [`COPPER_WORD_W-1:0] xr_target(
        input copper_isa_pkg::opcode_t        op,
        input logic [`COPPER_MOVE_ADDR_W-1:0] field
    );
        case (op)
            copper_isa_pkg::OP_MOVER: return {8'h00, field[7:0]};
            copper_isa_pkg::OP_MOVEF: return copper_bus_pkg::XR_TILE_MEM | {4'h0, field};
            copper_isa_pkg::OP_MOVEP: return copper_bus_pkg::XR_COLOR_MEM | {8'h00, field[7:0]};
            default: return copper_bus_pkg::XR_COPPER_MEM | {5'h00, field[10:0]};
        endcase
    endfunction

    // Random field and data; a negative time means the write must not happen
    task automatic add_move(input copper_isa_pkg::opcode_t op, input int at);
        copper_isa_pkg::insn_t w;
        w = '0;
        w.mv.opcode = op;
        w.mv.addr   = `COPPER_MOVE_ADDR_W'($urandom);
        w.mv.data   = `COPPER_WORD_W'($urandom);
        prog.push_back(w);
        if (at >= 0) begin
            exp_addr.push_back(xr_target(op, w.mv.addr));
            exp_data.push_back(w.mv.data);
            exp_at.push_back(at);
        end
    endtask

    // WAIT, SKIP and JMP with the JMP target in y
    task automatic add_pos(input copper_isa_pkg::opcode_t op, input int y, input int x,
                           input bit ign_x, input bit ign_y);
        copper_isa_pkg::insn_t w;
        w = '0;
        w.pos.opcode   = op;
        w.pos.y        = `COPPER_POS_W'(y);
        w.pos.x        = `COPPER_POS_W'(x);
        w.pos.ignore_x = ign_x;
        w.pos.ignore_y = ign_y;
        prog.push_back(w);
    endtask

    // High word at the lower address
    task automatic load_program(input logic [`COPPER_PC_W-1:0] base);
        logic [`COPPER_PC_W-1:0] addr;
        addr = base;
        foreach (prog[i]) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = addr;
            load_data = prog[i][31:16];
            @(negedge clk);
            load_addr = addr + `COPPER_PC_W'(1);
            load_data = prog[i][15:0];
            addr      = addr + `COPPER_PC_W'(2);
        end
        @(negedge clk);
        load_en = 1'b0;
        prog.delete();
    endtask

    task automatic write_ctrl(input bit en, input logic [`COPPER_PC_W-1:0] pc);
        @(negedge clk);
        reg_wr_i    = 1'b1;
        reg_num_i   = copper_bus_pkg::XR_COPP_CTRL;
        reg_data_i  = {en, 4'b0000, pc};
        copper_on   = en;
        exp_init_pc = pc;
        @(negedge clk);
        reg_wr_i    = 1'b0;
    endtask

    // One full raster frame that ends with the beam held in vblank
    task automatic run_frame();
        frame_no++;
        for (int v = 0; v < V_TOTAL; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                @(negedge clk);
                h_count_i = `COPPER_POS_W'(h);
                v_count_i = `COPPER_POS_W'(v);
                vblank_i  = (v >= V_VISIBLE);
            end
        end
        assert (writes_seen == exp_addr.size())
            else report_failure($sformatf("%0d XR writes by the end of frame %0d, %0d expected",
                                          writes_seen, frame_no, exp_addr.size()));
    endtask

    // XR writes in order and at the expected beam position
    always @(posedge clk) begin
        int beam;
        if (!reset_i && xr_wr_en_o) begin
            beam = int'(v_count_i) * H_TOTAL + int'(h_count_i);
            assert (writes_seen < exp_addr.size())
                else report_failure($sformatf("unexpected XR write to %h at beam position %0d",
                                              xr_wr_addr_o, beam));
            assert (xr_wr_addr_o == exp_addr[writes_seen])
                else report_failure($sformatf("MISMATCH xr_wr_addr_o got %h expected %h",
                                              xr_wr_addr_o, exp_addr[writes_seen]));
            assert (xr_wr_data_o == exp_data[writes_seen])
                else report_failure($sformatf("MISMATCH xr_wr_data_o got %h expected %h",
                                              xr_wr_data_o, exp_data[writes_seen]));
            assert (beam == exp_at[writes_seen])
                else report_failure($sformatf("XR write at beam position %0d instead of %0d",
                                              beam, exp_at[writes_seen]));
            writes_seen++;
        end
    end

    // First fetch of a frame must come from the initial PC
    always @(posedge clk) begin
        if (!reset_i && coppermem_rd_en_o) begin
            fetch_frame[coppermem_rd_addr_o] = frame_no;
            if (first_fetch_frame != frame_no) begin
                first_fetch_frame = frame_no;
                assert (coppermem_rd_addr_o == exp_init_pc)
                    else report_failure($sformatf("MISMATCH coppermem_rd_addr_o got %h expected %h",
                                                  coppermem_rd_addr_o, exp_init_pc));
            end
        end
    end

    // Quiet while disabled and no fetch during vblank
    assert property (@(posedge clk) disable iff (reset_i)
                     !copper_on |-> (!xr_wr_en_o && !coppermem_rd_en_o))
        else report_failure("copper fetched or wrote while disabled");
    assert property (@(posedge clk) disable iff (reset_i) vblank_i |-> !coppermem_rd_en_o)
        else report_failure("copper fetched program words during vblank");

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before all test frames completed");
    end

    initial begin
        logic [`COPPER_PC_W-1:0] pc;
        int                      a_first;
        int                      y1;
        int                      x1;
        int                      y2;
        int                      x3;
        void'($urandom(29908));
        reset_i           = 1'b1;
        vblank_i          = 1'b1;
        reg_wr_i          = 1'b0;
        reg_num_i         = '0;
        reg_data_i        = '0;
        h_count_i         = '0;
        v_count_i         = `COPPER_POS_W'(V_VISIBLE);
        load_en           = 1'b0;
        load_addr         = '0;
        load_data         = '0;
        copper_on         = 1'b0;
        exp_init_pc       = '0;
        writes_seen       = 0;
        frame_no          = 0;
        first_fetch_frame = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;

        // Frame with the copper still disabled
        run_frame();

        // Four MOVE variants back to back 4 cycles apart with the first at 5
        pc      = `COPPER_PC_W'($urandom_range(1023, 0));
        a_first = exp_addr.size();
        add_move(copper_isa_pkg::OP_MOVER, 5);
        add_move(copper_isa_pkg::OP_MOVEF, 9);
        add_move(copper_isa_pkg::OP_MOVEP, 13);
        add_move(copper_isa_pkg::OP_MOVEC, 17);
        add_pos(copper_isa_pkg::OP_WAIT, 0, 0, 1'b1, 1'b1);
        load_program(pc);
        write_ctrl(1'b1, pc);
        run_frame();
        // Same program again after vblank restart
        for (int i = a_first; i < a_first + 4; i++) begin
            exp_addr.push_back(exp_addr[i]);
            exp_data.push_back(exp_data[i]);
            exp_at.push_back(exp_at[i]);
        end
        run_frame();

        // WAIT on both axes, on y only, then on x only
        // The ignored axis holds a position not yet reached
        pc = `COPPER_PC_W'($urandom_range(1500, 1024));
        y1 = $urandom_range(3, 2);
        x1 = $urandom_range(29, 10);
        y2 = y1 + 3;
        x3 = $urandom_range(31, 12);
        add_pos(copper_isa_pkg::OP_WAIT, y1, x1, 1'b0, 1'b0);
        add_move(copper_isa_pkg::OP_MOVER, y1 * H_TOTAL + x1 + 5);
        add_pos(copper_isa_pkg::OP_WAIT, y2, H_TOTAL - 1, 1'b1, 1'b0);
        add_move(copper_isa_pkg::OP_MOVEF, y2 * H_TOTAL + 5);
        add_pos(copper_isa_pkg::OP_WAIT, V_VISIBLE - 1, x3, 1'b0, 1'b1);
        add_move(copper_isa_pkg::OP_MOVEP, y2 * H_TOTAL + x3 + 5);
        add_pos(copper_isa_pkg::OP_WAIT, 0, 0, 1'b1, 1'b1);
        load_program(pc);
        write_ctrl(1'b1, pc);
        run_frame();
        assert (fetch_frame[pc + `COPPER_PC_W'(14)] != frame_no)
            else report_failure("instruction after a WAIT with both axes ignored was fetched");

        // SKIP taken and not taken, JMP over three moves, illegal opcode
        pc = `COPPER_PC_W'($urandom_range(1500, 0));
        add_pos(copper_isa_pkg::OP_SKIP, 0, 0, 1'b0, 1'b0);
        add_move(copper_isa_pkg::OP_MOVER, -1);
        add_pos(copper_isa_pkg::OP_SKIP, 9, 0, 1'b0, 1'b0);
        add_move(copper_isa_pkg::OP_MOVEP, 13);
        add_pos(copper_isa_pkg::OP_JMP, int'(pc) + 16, 0, 1'b0, 1'b0);
        add_move(copper_isa_pkg::OP_MOVEF, -1);
        add_move(copper_isa_pkg::OP_MOVEC, -1);
        add_move(copper_isa_pkg::OP_MOVER, -1);
        prog.push_back({4'hF, 28'($urandom)});
        // Illegal opcode costs one extra INIT cycle
        add_move(copper_isa_pkg::OP_MOVEC, 26);
        add_pos(copper_isa_pkg::OP_SKIP, V_TOTAL - 1, H_TOTAL - 1, 1'b1, 1'b1);
        add_move(copper_isa_pkg::OP_MOVER, -1);
        add_pos(copper_isa_pkg::OP_WAIT, 0, 0, 1'b1, 1'b1);
        load_program(pc);
        write_ctrl(1'b1, pc);
        run_frame();
        assert (fetch_frame[pc + `COPPER_PC_W'(16)] == frame_no)
            else report_failure("JMP target was never fetched");
        assert (fetch_frame[pc + `COPPER_PC_W'(2)] != frame_no)
            else report_failure("instruction after a taken SKIP was fetched");
        assert (fetch_frame[pc + `COPPER_PC_W'(10)] != frame_no)
            else report_failure("instruction after a JMP was fetched");
        assert (fetch_frame[pc + `COPPER_PC_W'(22)] != frame_no)
            else report_failure("instruction after a SKIP with both axes ignored was fetched");

        // Disabled again so the loaded program stays idle
        write_ctrl(1'b0, pc);
        run_frame();

        if (writes_seen > 0 && writes_seen == exp_addr.size()) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_failure($sformatf("%0d XR writes seen in total, %0d expected",
                                     writes_seen, exp_addr.size()));
        end
    end

endmodule

//--- copper_tb_mem.sv
// Copper program memory model, 2K x 16 with one cycle of read latency
// Unloaded words hold a fill pattern that decodes as an illegal opcode
// Load port writes one word per clock and is used only by the testbench
`timescale 1ns/100ps
`include "copper_defines.svh"

module copper_tb_mem (
    input  logic                      clk,
    input  logic                      rd_en_i,
    input  logic [`COPPER_PC_W-1:0]   rd_addr_i,
    output logic [`COPPER_WORD_W-1:0] rd_data_o,
    input  logic                      load_en_i,
    input  logic [`COPPER_PC_W-1:0]   load_addr_i,
    input  logic [`COPPER_WORD_W-1:0] load_data_i
);

    localparam int DEPTH = 1 << `COPPER_PC_W;

    logic [`COPPER_WORD_W-1:0] mem [0:DEPTH-1];

    // Top nibble 0xF, low bits carry the whole word address
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = {5'h1F, `COPPER_PC_W'(a)};
        end
    end

    always @(posedge clk) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end
        // Data follows the address by one clock
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

//--- src.f
+incdir+.
copper_isa_pkg.sv
copper_bus_pkg.sv
copper_pc_unit.sv
copper_sequencer.sv
copper_executor.sv
copper.sv
copper_tb_mem.sv
copper_tb.sv
